//--- hdl/aes_consts.svh
// AES-128 sizing macros, included by the package and by any module that needs them
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// cipher rounds for a 128-bit key
`define AES_ROUNDS 10

// state and cipher key width in bits
`define AES_BLOCK_BITS 128

// key schedule word width in bits
`define AES_WORD_BITS 32

`endif

//--- hdl/aes_pkg.sv
// shared AES-128 types and GF(2^8) helper, imported by the design modules
`include "aes_consts.svh"

package aes_pkg;

   // state or key, byte 0 in the top bits, columns as in FIPS-197
   typedef logic [`AES_BLOCK_BITS-1:0] aes_block_t;

   // one key schedule word
   typedef logic [`AES_WORD_BITS-1:0] aes_word_t;

   // round index, 0 to 10
   typedef logic [3:0] aes_round_t;

   // one slot of the round ring
   typedef struct packed {
      logic       busy;
      aes_round_t round;
      aes_block_t data;
   } aes_slot_t;

   // multiply by x in GF(2^8)
   // reduction by the AES polynomial 0x11b
   function automatic logic [7:0] aes_xtime(input logic [7:0] b);
      return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
   endfunction

endpackage

//--- hdl/aes_key_if.sv
// round-key read channel from the key schedule to the round ring
`timescale 1ns/1ps

interface aes_key_if;
   import aes_pkg::*;

   // high once all eleven round keys are stored
   logic       key_ready;
   // whitening key, xored on entry
   aes_block_t key0;
   // round requested by stage c
   aes_round_t rd_round;
   // stored key at rd_round, no register in the path
   aes_block_t rd_key;

   // schedule side owns the table
   modport sched (output key_ready, output key0, output rd_key, input rd_round);

   // ring side only reads
   modport ring (input key_ready, input key0, input rd_key, output rd_round);

endinterface

//--- hdl/aes_sub_bytes.sv
// forward AES S-box on NBYTES parallel byte lanes, used by the ring and the key schedule
`timescale 1ns/1ps

module aes_sub_bytes
#(
   parameter int NBYTES = 16
)
(
   input  logic [8*NBYTES-1:0] i_data,
   output logic [8*NBYTES-1:0] o_data
);

   // forward table
   // entry 0 sits in the top byte
   localparam logic [0:255][7:0] SBOX = {
      128'h637c777bf26b6fc53001672bfed7ab76,
      128'hca82c97dfa5947f0add4a2af9ca472c0,
      128'hb7fd9326363ff7cc34a5e5f171d83115,
      128'h04c723c31896059a071280e2eb27b275,
      128'h09832c1a1b6e5aa0523bd6b329e32f84,
      128'h53d100ed20fcb15b6acbbe394a4c58cf,
      128'hd0efaafb434d338545f9027f503c9fa8,
      128'h51a3408f929d38f5bcb6da2110fff3d2,
      128'hcd0c13ec5f974417c4a77e3d645d1973,
      128'h60814fdc222a908846eeb814de5e0bdb,
      128'he0323a0a4906245cc2d3ac629195e479,
      128'he7c8376d8dd54ea96c56f4ea657aae08,
      128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
      128'h703eb5664803f60e613557b986c11d9e,
      128'he1f8981169d98e949b1e87e9ce5528df,
      128'h8ca1890dbfe6426841992d0fb054bb16
   };

   always_comb
   begin
      // one lookup per byte lane, lanes are independent
      for (int i = 0; i < NBYTES; i++)
      begin
         o_data[8*i +: 8] = SBOX[i_data[8*i +: 8]];
      end
      // table is fully populated
      // a known byte can only map to a known byte
      if (!$isunknown(i_data))
      begin
         assert (!$isunknown(o_data))
         else $error("aes_sub_bytes: unknown output for a known input");
      end
   end

endmodule

//--- hdl/aes_key_schedule.sv
// sequential AES-128 key expansion, stores eleven round keys for the round ring
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_key_schedule
(
   input  logic                clk,
   input  logic                n_rst,
   input  logic                i_key_req,
   input  aes_pkg::aes_block_t i_key,
   output logic                o_key_ack,
   aes_key_if.sched            key
);
   import aes_pkg::*;

   typedef enum logic [1:0] {KS_IDLE, KS_EXPAND, KS_ACK} ks_state_t;

   ks_state_t  state;
   aes_round_t cnt;
   logic [7:0] rcon;
   aes_block_t rkeys [0:`AES_ROUNDS];
   aes_block_t prev_key;
   aes_word_t  w0, w1, w2, w3;
   aes_word_t  sub_word;
   aes_word_t  temp;
   aes_word_t  n0, n1, n2, n3;

   // key of the round before the one being built
   assign prev_key = rkeys[cnt - 4'd1];
   assign {w0, w1, w2, w3} = prev_key;

   // SubWord of RotWord(w3)
   aes_sub_bytes #(.NBYTES(4)) u_sub_word (
      .i_data ({w3[23:0], w3[31:24]}),
      .o_data (sub_word)
   );

   // round constant lands in the top byte
   assign temp = sub_word ^ {rcon, 24'h0};

   // each word chains off the one before it
   assign n0 = w0 ^ temp;
   assign n1 = w1 ^ n0;
   assign n2 = w2 ^ n1;
   assign n3 = w3 ^ n2;

   // read side for the ring
   assign key.key0 = rkeys[0];
   assign key.rd_key = rkeys[key.rd_round];

   always_ff @(posedge clk or negedge n_rst)
   begin
      if (!n_rst)
      begin
         state <= KS_IDLE;
         cnt <= '0;
         rcon <= 8'h01;
         o_key_ack <= 1'b0;
         key.key_ready <= 1'b0;
      end
      else
      begin
         case (state)
            KS_IDLE:
            begin
               // table goes stale as soon as a new key arrives
               if (i_key_req)
               begin
                  state <= KS_EXPAND;
                  cnt <= 4'd1;
                  rcon <= 8'h01;
                  key.key_ready <= 1'b0;
               end
            end
            KS_EXPAND:
            begin
               rcon <= aes_xtime(rcon);
               if (cnt == `AES_ROUNDS)
               begin
                  state <= KS_ACK;
                  o_key_ack <= 1'b1;
                  key.key_ready <= 1'b1;
               end
               else
               begin
                  cnt <= cnt + 4'd1;
               end
            end
            KS_ACK:
            begin
               // hold ack until the host lets go
               if (!i_key_req)
               begin
                  state <= KS_IDLE;
                  o_key_ack <= 1'b0;
               end
            end
            default: state <= KS_IDLE;
         endcase
      end
   end

   // key table
   // entry 0 on the request, one new entry per expand cycle
   always_ff @(posedge clk)
   begin
      if (state == KS_IDLE && i_key_req)
         rkeys[0] <= i_key;
      else if (state == KS_EXPAND)
         rkeys[cnt] <= {n0, n1, n2, n3};
   end

   // host must see ack fall before starting the next load
   a_req_after_ack: assert property (@(posedge clk) disable iff (!n_rst)
      $rose(i_key_req) |-> !o_key_ack)
      else $error("aes_key_schedule: key request raised while ack still high");

endmodule

//--- hdl/aes_block_in.sv
// four-phase plaintext input port, holds one block until the round ring takes it
`timescale 1ns/1ps

module aes_block_in
(
   input  logic                clk,
   input  logic                n_rst,
   input  logic                i_blk_req,
   input  aes_pkg::aes_block_t i_blk,
   output logic                o_blk_ack,
   output logic                o_valid,
   output aes_pkg::aes_block_t o_block,
   input  logic                i_take
);
   import aes_pkg::*;

   typedef enum logic [1:0] {BI_IDLE, BI_HELD, BI_ACKED, BI_WAIT_LOW} bi_state_t;

   bi_state_t  state;
   aes_block_t blk_q;

   always_ff @(posedge clk or negedge n_rst)
   begin
      if (!n_rst)
      begin
         state <= BI_IDLE;
      end
      else
      begin
         case (state)
            // empty, capture on the first request cycle
            BI_IDLE: if (i_blk_req) state <= BI_HELD;
            // offered to the ring
            BI_HELD: if (i_take) state <= BI_ACKED;
            // ack up until the host drops req
            BI_ACKED: if (!i_blk_req) state <= BI_WAIT_LOW;
            // ack is low again, one settle cycle before empty
            default: state <= BI_IDLE;
         endcase
      end
   end

   // payload only changes on capture
   always_ff @(posedge clk)
   begin
      if (state == BI_IDLE && i_blk_req)
         blk_q <= i_blk;
   end

   assign o_valid = (state == BI_HELD);
   assign o_blk_ack = (state == BI_ACKED);
   assign o_block = blk_q;

   // ring may only take what is offered
   a_take_valid: assert property (@(posedge clk) disable iff (!n_rst)
      i_take |-> o_valid)
      else $error("aes_block_in: take without a held block");

endmodule

//--- hdl/aes_round_ring.sv
// three-stage AES-128 round ring, up to three blocks loop ten rounds each, frozen on full output
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_round_ring
(
   input  logic                clk,
   input  logic                n_rst,
   input  logic                i_valid,
   input  aes_pkg::aes_block_t i_block,
   output logic                o_take,
   aes_key_if.ring             key,
   output logic                o_done,
   output aes_pkg::aes_block_t o_block,
   input  logic                i_full
);
   import aes_pkg::*;

   aes_slot_t  slot_a, slot_b, slot_c;
   aes_slot_t  a_in;
   aes_block_t a_sub;
   aes_block_t b_shift;
   aes_block_t b_mix;
   logic       last_b;
   logic       free_c;
   logic       stall;
   logic       load;

   // rotate row r left by r columns
   // byte index is row + 4*col, byte 0 at the top
   function automatic aes_block_t shift_rows(input aes_block_t s);
      aes_block_t r;
      for (int c = 0; c < 4; c++)
      begin
         for (int row = 0; row < 4; row++)
         begin
            r[127 - 8*(row + 4*c) -: 8] = s[127 - 8*(row + 4*((c + row) % 4)) -: 8];
         end
      end
      return r;
   endfunction

   // one column times the fixed {02 03 01 01} matrix
   function automatic aes_word_t mix_column(input aes_word_t col);
      logic [7:0] a0, a1, a2, a3;
      logic [7:0] t;
      {a0, a1, a2, a3} = col;
      t = a0 ^ a1 ^ a2 ^ a3;
      return {a0 ^ t ^ aes_xtime(a0 ^ a1),
              a1 ^ t ^ aes_xtime(a1 ^ a2),
              a2 ^ t ^ aes_xtime(a2 ^ a3),
              a3 ^ t ^ aes_xtime(a3 ^ a0)};
   endfunction

   // finished block sits in stage c
   assign o_done = slot_c.busy && (slot_c.round == `AES_ROUNDS);
   assign o_block = slot_c.data;

   // slot coming round to stage a can take a new block
   assign free_c = !slot_c.busy || o_done;

   // nowhere to put the result, hold everything
   assign stall = o_done && i_full;

   // no entry while the key table is being rebuilt
   assign load = free_c && i_valid && key.key_ready;
   assign o_take = load && !stall;

   // stage a input mux
   always_comb
   begin
      if (load)
      begin
         a_in.busy = 1'b1;
         a_in.round = '0;
         a_in.data = i_block ^ key.key0;
      end
      else if (free_c)
      begin
         // empty or retired slot goes round idle
         a_in.busy = 1'b0;
         a_in.round = '0;
         a_in.data = slot_c.data;
      end
      else
      begin
         a_in = slot_c;
      end
   end

   // stage a, byte substitution
   aes_sub_bytes #(.NBYTES(16)) u_sub_bytes (
      .i_data (a_in.data),
      .o_data (a_sub)
   );

   // stage b, shift rows then mix columns
   // slot_a.round counts completed rounds, so 9 means the last one is under way
   assign last_b = (slot_a.round == `AES_ROUNDS - 1);
   assign b_shift = shift_rows(slot_a.data);

   always_comb
   begin
      for (int c = 0; c < 4; c++)
      begin
         b_mix[127 - 32*c -: 32] = mix_column(b_shift[127 - 32*c -: 32]);
      end
   end

   // stage c reads the key of the round it completes
   assign key.rd_round = slot_b.round + 4'd1;

   always_ff @(posedge clk or negedge n_rst)
   begin
      if (!n_rst)
      begin
         slot_a <= '0;
         slot_b <= '0;
         slot_c <= '0;
      end
      else if (!stall)
      begin
         slot_a.busy <= a_in.busy;
         slot_a.round <= a_in.round;
         slot_a.data <= a_sub;
         slot_b.busy <= slot_a.busy;
         slot_b.round <= slot_a.round;
         slot_b.data <= last_b ? b_shift : b_mix;
         slot_c.busy <= slot_b.busy;
         // idle slots keep round 0
         slot_c.round <= slot_b.busy ? slot_b.round + 4'd1 : slot_b.round;
         slot_c.data <= slot_b.data ^ key.rd_key;
      end
   end

   // retirement at stage c keeps every slot inside the key table
   a_round_max: assert property (@(posedge clk) disable iff (!n_rst)
      (slot_a.round <= `AES_ROUNDS) && (slot_b.round <= `AES_ROUNDS)
      && (slot_c.round <= `AES_ROUNDS))
      else $error("aes_round_ring: slot round past the last round");

endmodule

//--- hdl/aes_block_out.sv
// one-block ciphertext buffer with the four-phase output handshake
`timescale 1ns/1ps

module aes_block_out
(
   input  logic                clk,
   input  logic                n_rst,
   input  logic                i_done,
   input  aes_pkg::aes_block_t i_block,
   output logic                o_full,
   output logic                o_ct_req,
   output aes_pkg::aes_block_t o_ct,
   input  logic                i_ct_ack
);
   import aes_pkg::*;

   typedef enum logic [1:0] {OB_EMPTY, OB_LOADED, OB_REQ, OB_ACKED} ob_state_t;

   ob_state_t  state;
   aes_block_t ct_q;

   always_ff @(posedge clk or negedge n_rst)
   begin
      if (!n_rst)
      begin
         state <= OB_EMPTY;
      end
      else
      begin
         case (state)
            // take the finished block from stage c
            OB_EMPTY: if (i_done) state <= OB_LOADED;
            // req goes up a cycle after the write
            OB_LOADED: state <= OB_REQ;
            OB_REQ: if (i_ct_ack) state <= OB_ACKED;
            // consumer still holds ack, buffer not free yet
            default: if (!i_ct_ack) state <= OB_EMPTY;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == OB_EMPTY && i_done)
         ct_q <= i_block;
   end

   assign o_full = (state != OB_EMPTY);
   assign o_ct_req = (state == OB_REQ);
   assign o_ct = ct_q;

   // data must not move under a pending request
   a_ct_stable: assert property (@(posedge clk) disable iff (!n_rst)
      o_ct_req |=> $stable(o_ct))
      else $error("aes_block_out: o_ct changed while o_ct_req high");

endmodule

//--- hdl/aes_encrypt_top.sv
// AES-128 encryption engine top, key port, plaintext port and ciphertext port
`timescale 1ns/1ps

module aes_encrypt_top
(
   input  logic                clk,
   input  logic                n_rst,
   // key load handshake
   input  logic                i_key_req,
   input  aes_pkg::aes_block_t i_key,
   output logic                o_key_ack,
   // plaintext handshake
   input  logic                i_blk_req,
   input  aes_pkg::aes_block_t i_blk,
   output logic                o_blk_ack,
   // ciphertext handshake
   output logic                o_ct_req,
   output aes_pkg::aes_block_t o_ct,
   input  logic                i_ct_ack
);
   import aes_pkg::*;

   // round key reads
   aes_key_if  key_bus ();

   // input port to ring
   logic       blk_valid;
   aes_block_t blk_data;
   logic       blk_take;

   // ring to output buffer
   logic       ring_done;
   aes_block_t ring_block;
   logic       out_full;

   aes_key_schedule u_key_schedule (
      .clk       (clk),
      .n_rst     (n_rst),
      .i_key_req (i_key_req),
      .i_key     (i_key),
      .o_key_ack (o_key_ack),
      .key       (key_bus.sched)
   );

   aes_block_in u_block_in (
      .clk       (clk),
      .n_rst     (n_rst),
      .i_blk_req (i_blk_req),
      .i_blk     (i_blk),
      .o_blk_ack (o_blk_ack),
      .o_valid   (blk_valid),
      .o_block   (blk_data),
      .i_take    (blk_take)
   );

   aes_round_ring u_round_ring (
      .clk     (clk),
      .n_rst   (n_rst),
      .i_valid (blk_valid),
      .i_block (blk_data),
      .o_take  (blk_take),
      .key     (key_bus.ring),
      .o_done  (ring_done),
      .o_block (ring_block),
      .i_full  (out_full)
   );

   aes_block_out u_block_out (
      .clk      (clk),
      .n_rst    (n_rst),
      .i_done   (ring_done),
      .i_block  (ring_block),
      .o_full   (out_full),
      .o_ct_req (o_ct_req),
      .o_ct     (o_ct),
      .i_ct_ack (i_ct_ack)
   );

endmodule

//--- dv/aes_encrypt_tb.sv
// trace-driven testbench for the AES-128 engine, reads dv/aes_trace.txt, run through run_sim.sh
`timescale 1ns/1ps

module aes_encrypt_tb;
   import aes_pkg::*;

   logic       clk;
   logic       n_rst;
   logic       i_key_req;
   aes_block_t i_key;
   logic       o_key_ack;
   logic       i_blk_req;
   aes_block_t i_blk;
   logic       o_blk_ack;
   logic       o_ct_req;
   aes_block_t o_ct;
   logic       i_ct_ack;

   // trace lines, kind plus one or two hex columns
   byte        line_kind [$];
   aes_block_t line_a [$];
   aes_block_t line_b [$];
   // ciphertexts still owed, oldest first
   aes_block_t exp_q [$];

   int unsigned lcg_state = 14219;
   int          err_count = 0;
   int          check_count = 0;
   int          sent_count = 0;
   int          recv_count = 0;
   int          n_blocks = 0;
   int          n_keys = 0;
   int          cycle_limit = 0;
   int          cycles = 0;

   // previous negedge samples for the protocol monitor
   logic        key_req_q = 1'b0;
   logic        key_ack_q = 1'b0;
   logic        blk_req_q = 1'b0;
   logic        blk_ack_q = 1'b0;
   logic        ct_req_q = 1'b0;
   aes_block_t  ct_hold = '0;

   aes_encrypt_top DUT (
      .clk       (clk),
      .n_rst     (n_rst),
      .i_key_req (i_key_req),
      .i_key     (i_key),
      .o_key_ack (o_key_ack),
      .i_blk_req (i_blk_req),
      .i_blk     (i_blk),
      .o_blk_ack (o_blk_ack),
      .o_ct_req  (o_ct_req),
      .o_ct      (o_ct),
      .i_ct_ack  (i_ct_ack)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // linear congruential step, upper bits are the better ones
   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   task automatic check_bit(input string name, input logic got, input logic want);
      check_count++;
      if (got !== want)
      begin
         err_count++;
         $display("error at %0t: %s is %b, expected %b", $time, name, got, want);
      end
   endtask

   task automatic check_block(input string name, input aes_block_t got, input aes_block_t want);
      check_count++;
      if (got !== want)
      begin
         err_count++;
         $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
      end
   endtask

   task automatic read_trace();
      int         fd;
      int         n;
      string      line;
      aes_block_t a;
      aes_block_t b;
      fd = $fopen("dv/aes_trace.txt", "r");
      if (fd == 0)
      begin
         err_count++;
         $display("could not open the trace file dv/aes_trace.txt");
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         // comments and blank lines
         if (n < 3 || line[0] == "#")
            continue;
         if (line[0] == "K" && $sscanf(line, "K %h", a) == 1)
         begin
            line_kind.push_back("K");
            line_a.push_back(a);
            line_b.push_back('0);
            n_keys++;
         end
         else if (line[0] == "E" && $sscanf(line, "E %h %h", a, b) == 2)
         begin
            line_kind.push_back("E");
            line_a.push_back(a);
            line_b.push_back(b);
            n_blocks++;
         end
         else
         begin
            err_count++;
            $display("trace line not understood: %s", line);
         end
      end
      $fclose(fd);
   endtask

   // four-phase key load, only once every earlier block is back
   task automatic load_key(input aes_block_t k);
      while (exp_q.size() != 0)
         @(negedge clk);
      @(posedge clk);
      i_key <= k;
      i_key_req <= 1'b1;
      do @(negedge clk); while (!o_key_ack);
      @(posedge clk);
      i_key_req <= 1'b0;
      do @(negedge clk); while (o_key_ack);
   endtask

   // four-phase plaintext send, result queued before the DUT can answer
   task automatic send_block(input aes_block_t pt, input aes_block_t ct);
      @(posedge clk);
      i_blk <= pt;
      i_blk_req <= 1'b1;
      exp_q.push_back(ct);
      sent_count++;
      do @(negedge clk); while (!o_blk_ack);
      @(posedge clk);
      i_blk_req <= 1'b0;
      do @(negedge clk); while (o_blk_ack);
   endtask

   // watchdog sized from the trace
   initial
   begin
      wait (cycle_limit > 0);
      while (cycles < cycle_limit)
      begin
         @(posedge clk);
         cycles++;
      end
      err_count++;
      $display("run timed out after %0d cycles, %0d of %0d ciphertexts received",
               cycles, recv_count, sent_count);
      $display("errors %0d, checks %0d, ciphertexts %0d of %0d",
               err_count, check_count, recv_count, n_blocks);
      $display(">>> FAIL");
      $finish;
   end

   // acks fall only after their request, o_ct frozen under o_ct_req
   always @(negedge clk)
   begin
      if (n_rst)
      begin
         if (key_ack_q && !o_key_ack)
            check_bit("i_key_req", key_req_q, 1'b0);
         if (blk_ack_q && !o_blk_ack)
            check_bit("i_blk_req", blk_req_q, 1'b0);
         if (ct_req_q && o_ct_req)
            check_block("o_ct", o_ct, ct_hold);
      end
      key_req_q = i_key_req;
      key_ack_q = o_key_ack;
      blk_req_q = i_blk_req;
      blk_ack_q = o_blk_ack;
      ct_req_q = o_ct_req;
      ct_hold = o_ct;
   end

   // consumer side, random ack delay gives back-pressure
   initial
   begin
      aes_block_t want;
      int         delay;
      forever
      begin
         do @(negedge clk); while (!(n_rst && o_ct_req));
         if (exp_q.size() == 0)
         begin
            err_count++;
            $display("ciphertext %h arrived with no block outstanding", o_ct);
         end
         else
         begin
            want = exp_q.pop_front();
            check_block("o_ct", o_ct, want);
         end
         recv_count++;
         delay = int'(lcg_next() % 41);
         repeat (delay) @(posedge clk);
         @(posedge clk);
         i_ct_ack <= 1'b1;
         do @(negedge clk); while (o_ct_req);
         @(posedge clk);
         i_ct_ack <= 1'b0;
      end
   end

   // producer side and end of run
   initial
   begin
      n_rst = 1'b0;
      i_key_req = 1'b0;
      i_key = '0;
      i_blk_req = 1'b0;
      i_blk = '0;
      i_ct_ack = 1'b0;
      read_trace();
      cycle_limit = n_blocks * (30 + 40 + 10) + n_keys * 200;
      repeat (2) @(posedge clk);
      n_rst <= 1'b1;
      @(negedge clk);
      check_bit("o_key_ack", o_key_ack, 1'b0);
      check_bit("o_blk_ack", o_blk_ack, 1'b0);
      check_bit("o_ct_req", o_ct_req, 1'b0);
      foreach (line_kind[i])
      begin
         if (line_kind[i] == "K")
            load_key(line_a[i]);
         else
            send_block(line_a[i], line_b[i]);
      end
      while (exp_q.size() != 0)
         @(negedge clk);
      // buffer frees only once the last handshake is over
      while (o_ct_req || i_ct_ack)
         @(negedge clk);
      // quiet window, a duplicate would show up here
      repeat (40) @(negedge clk);
      $display("errors %0d, checks %0d, ciphertexts %0d of %0d",
               err_count, check_count, recv_count, n_blocks);
      if (err_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- dv/aes_trace.txt
# K <key>                      load a cipher key once all earlier blocks are back, hex
# E <plaintext> <ciphertext>   one block and its expected AES-128 result, hex
K 000102030405060708090a0b0c0d0e0f
E 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
K 2b7e151628aed2a6abf7158809cf4f3c
E 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
E 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
E ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
E 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
E f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
K 000102030405060708090a0b0c0d0e0f
E 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a

//--- verilog.f
+incdir+hdl
hdl/aes_pkg.sv
hdl/aes_key_if.sv
hdl/aes_sub_bytes.sv
hdl/aes_key_schedule.sv
hdl/aes_block_in.sv
hdl/aes_round_ring.sv
hdl/aes_block_out.sv
hdl/aes_encrypt_top.sv
dv/aes_encrypt_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the AES-128 testbench with Verilator, run it and scan the log
set -e -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module aes_encrypt_tb -f verilog.f
./obj_dir/Vaes_encrypt_tb | tee sim.log
if grep -q ">>> FAIL" sim.log
then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without failure"
